//--- dog_pkg.sv
// Shared types, path constants and colours for the dog layer; every block refers to them by scope
package dog_pkg;

    // ----------------------------------------
    // Raster bus and dog status
    // ----------------------------------------
    typedef struct packed {
        logic [11:0] hcount; // Pixel column
        logic [11:0] vcount; // Line number
        logic        hsync;
        logic        vsync;
        logic        hblnk;
        logic        vblnk;
        logic [11:0] rgb;    // 4 bits per colour
    } vga_bus_t;

    typedef enum logic [2:0] {
        DOG_IDLE = 3'd0, // Waiting at home
        DOG_WALK = 3'd1, // Walking left
        DOG_SPOT = 3'd2, // Short pause, sniffing
        DOG_JUMP = 3'd3, // Going up
        DOG_FALL = 3'd4  // Coming down
    } dog_state_t;

    typedef struct packed {
        logic [11:0] xpos;  // Integer part of x
        logic [11:0] ypos;  // Integer part of y
        logic [3:0]  photo; // Picture index
        dog_state_t  state;
    } dog_status_t;

    // ----------------------------------------
    // Path in integer pixels
    // ----------------------------------------
    localparam logic [11:0] DOG_HOME_X = 12'd1024; // Just off the right edge
    localparam logic [11:0] DOG_HOME_Y = 12'd595;
    localparam logic [11:0] WALK_END_X = 12'd650;
    localparam logic [11:0] SPOT_END_X = 12'd653;
    localparam logic [11:0] JUMP_TOP_Y = 12'd450;
    localparam logic [11:0] FALL_END_Y = 12'd600;

    // Steps per line, Q12.24, two's complement
    localparam logic [35:0] WALK_DX = -(36'd3 << 24);
    localparam logic [35:0] SPOT_DX = 36'd1 << 22; // +0.25
    localparam logic [35:0] JUMP_DX = -(36'd2 << 24);
    localparam logic [35:0] JUMP_DY = -(36'd4 << 24);
    localparam logic [35:0] FALL_DX = -(36'd2 << 24);
    localparam logic [35:0] FALL_DY = 36'd3 << 24;

    // Fixed pictures
    localparam logic [3:0] PHOTO_SPOT = 4'd6;
    localparam logic [3:0] PHOTO_JUMP = 4'd7;
    localparam logic [3:0] PHOTO_FALL = 4'd8;

    localparam int DOG_SIZE = 32; // Box edge in pixels

    localparam logic [11:0] BG_RGB = 12'h6AE; // Sky

    // One flat colour per picture, index 0 at the bottom
    localparam logic [8:0][11:0] DOG_PALETTE = {
        12'hE33, // 8 falling
        12'hF93, // 7 jumping
        12'hFF4, // 6 spotting
        12'h642, 12'h753, 12'h864,
        12'h975, 12'hA86, 12'hB97  // 0..5 walk cycle
    };

endpackage

//--- vga_timing.sv
// Raster timing generator: pixel and line counters, sync/blank levels and a line-start pulse
`timescale 1ns/10ps

module vga_timing #(
    parameter int H_ACTIVE = 1024,
    parameter int H_FRONT  = 24,
    parameter int H_SYNC   = 136,
    parameter int H_TOTAL  = 1344,
    parameter int V_ACTIVE = 768,
    parameter int V_FRONT  = 3,
    parameter int V_SYNC   = 6,
    parameter int V_TOTAL  = 806
) (
    input  logic             clk,
    input  logic             rst,
    output dog_pkg::vga_bus_t vga_out,
    output logic             line_tick
);

    // ----------------------------------------
    // Counters
    // ----------------------------------------
    logic [11:0] hcount, vcount;
    logic [11:0] hcount_nxt, vcount_nxt;
    logic        hsync, vsync, hblnk, vblnk;
    logic        hsync_nxt, vsync_nxt, hblnk_nxt, vblnk_nxt;
    logic        line_end; // Last pixel of a line

    always_comb begin : cnt_comb_blk
        line_end   = (hcount == 12'(H_TOTAL - 1));
        hcount_nxt = line_end ? 12'd0 : hcount + 12'd1;
        vcount_nxt = vcount;
        if (line_end) begin
            vcount_nxt = (vcount == 12'(V_TOTAL - 1)) ? 12'd0 : vcount + 12'd1;
        end
    end

    // Levels worked out on the next count so they line up with it
    always_comb begin : level_comb_blk
        hblnk_nxt = (hcount_nxt >= 12'(H_ACTIVE));
        vblnk_nxt = (vcount_nxt >= 12'(V_ACTIVE));
        hsync_nxt = (hcount_nxt >= 12'(H_ACTIVE + H_FRONT)) &&
                    (hcount_nxt <  12'(H_ACTIVE + H_FRONT + H_SYNC));
        vsync_nxt = (vcount_nxt >= 12'(V_ACTIVE + V_FRONT)) &&
                    (vcount_nxt <  12'(V_ACTIVE + V_FRONT + V_SYNC));
    end

    always_ff @(posedge clk) begin : timing_seq_blk
        if (rst) begin
            hcount    <= 12'd0;
            vcount    <= 12'd0;
            hsync     <= 1'b0;
            vsync     <= 1'b0;
            hblnk     <= 1'b0; // 0,0 is an active pixel
            vblnk     <= 1'b0;
            line_tick <= 1'b0;
        end else begin
            hcount    <= hcount_nxt;
            vcount    <= vcount_nxt;
            hsync     <= hsync_nxt;
            vsync     <= vsync_nxt;
            hblnk     <= hblnk_nxt;
            vblnk     <= vblnk_nxt;
            line_tick <= (hcount_nxt == 12'(H_ACTIVE)); // First blank pixel of the line
        end
    end

    // ----------------------------------------
    // Output bus
    // ----------------------------------------
    always_comb begin : bus_comb_blk
        vga_out.hcount = hcount;
        vga_out.vcount = vcount;
        vga_out.hsync  = hsync;
        vga_out.vsync  = vsync;
        vga_out.hblnk  = hblnk;
        vga_out.vblnk  = vblnk;
        vga_out.rgb    = dog_pkg::BG_RGB; // Plain background, dog drawn later
    end

    // Sync pulse must drop after exactly H_SYNC clocks
    hsync_width_chk: assert property (
        @(posedge clk) disable iff (rst)
        $rose(hsync) |-> ##H_SYNC !hsync
    ) else $error("hsync held longer than %0d clocks", H_SYNC);

endmodule

//--- dog_ctl.sv
// Dog motion controller: walks the dog along a fixed path once per game start, one step per line
`timescale 1ns/10ps

module dog_ctl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 game_enable,
    input  logic                 line_tick,
    output dog_pkg::dog_status_t dog
);

    // ----------------------------------------
    // Registers and next values
    // ----------------------------------------
    dog_pkg::dog_state_t state, state_nxt;

    logic [35:0] x_q, y_q;     // Q12.24 position
    logic [35:0] x_nxt, y_nxt;
    logic [3:0]  photo_q, photo_nxt;
    logic [35:0] walk_x;       // x after a walk step
    logic [2:0]  walk_phase;   // Animation phase from walk position
    logic [11:0] x_int, y_int;

    assign x_int = x_q[35:24];
    assign y_int = y_q[35:24];

    // ----------------------------------------
    // State register
    // ----------------------------------------
    always_ff @(posedge clk) begin : state_seq_blk
        if (rst) begin
            state <= dog_pkg::DOG_IDLE;
        end else if (line_tick) begin
            state <= state_nxt; // Moves only on a line start
        end
    end

    // ----------------------------------------
    // Next state
    // ----------------------------------------
    always_comb begin : state_comb_blk
        case (state)
            dog_pkg::DOG_IDLE: begin
                state_nxt = game_enable ? dog_pkg::DOG_WALK : dog_pkg::DOG_IDLE;
            end
            dog_pkg::DOG_WALK: begin
                state_nxt = (x_int >= dog_pkg::WALK_END_X) ? dog_pkg::DOG_WALK
                                                           : dog_pkg::DOG_SPOT;
            end
            dog_pkg::DOG_SPOT: begin
                state_nxt = (x_int < dog_pkg::SPOT_END_X) ? dog_pkg::DOG_SPOT
                                                          : dog_pkg::DOG_JUMP;
            end
            dog_pkg::DOG_JUMP: begin
                state_nxt = (y_int > dog_pkg::JUMP_TOP_Y) ? dog_pkg::DOG_JUMP
                                                          : dog_pkg::DOG_FALL;
            end
            dog_pkg::DOG_FALL: begin
                state_nxt = (y_int < dog_pkg::FALL_END_Y) ? dog_pkg::DOG_FALL
                                                          : dog_pkg::DOG_IDLE;
            end
            default: state_nxt = dog_pkg::DOG_IDLE; // Recover from anything odd
        endcase
    end

    // ----------------------------------------
    // Step and picture for the next state
    // ----------------------------------------
    assign walk_x     = x_q + dog_pkg::WALK_DX;
    assign walk_phase = walk_x[29:27]; // Integer x bits 5:3

    always_comb begin : out_comb_blk
        x_nxt     = x_q;
        y_nxt     = y_q;
        photo_nxt = photo_q;
        case (state_nxt)
            dog_pkg::DOG_IDLE: begin
                x_nxt     = {dog_pkg::DOG_HOME_X, 24'd0}; // Back home
                y_nxt     = {dog_pkg::DOG_HOME_Y, 24'd0};
                photo_nxt = 4'd0;
            end
            dog_pkg::DOG_WALK: begin
                x_nxt     = walk_x;
                // Six-picture cycle, phases 6 and 7 fold to 0
                photo_nxt = (walk_phase > 3'd5) ? 4'd0 : {1'b0, walk_phase};
            end
            dog_pkg::DOG_SPOT: begin
                x_nxt     = x_q + dog_pkg::SPOT_DX; // Creeps right
                photo_nxt = dog_pkg::PHOTO_SPOT;
            end
            dog_pkg::DOG_JUMP: begin
                x_nxt     = x_q + dog_pkg::JUMP_DX;
                y_nxt     = y_q + dog_pkg::JUMP_DY; // Up the screen
                photo_nxt = dog_pkg::PHOTO_JUMP;
            end
            dog_pkg::DOG_FALL: begin
                x_nxt     = x_q + dog_pkg::FALL_DX;
                y_nxt     = y_q + dog_pkg::FALL_DY;
                photo_nxt = dog_pkg::PHOTO_FALL;
            end
            default: begin
                x_nxt     = x_q;
                y_nxt     = y_q;
                photo_nxt = photo_q;
            end
        endcase
    end

    // ----------------------------------------
    // Position and picture registers
    // ----------------------------------------
    always_ff @(posedge clk) begin : pos_seq_blk
        if (rst) begin
            x_q     <= {dog_pkg::DOG_HOME_X, 24'd0};
            y_q     <= {dog_pkg::DOG_HOME_Y, 24'd0};
            photo_q <= 4'd0;
        end else if (line_tick) begin
            x_q     <= x_nxt;
            y_q     <= y_nxt;
            photo_q <= photo_nxt;
        end
    end

    assign dog = '{xpos: x_int, ypos: y_int, photo: photo_q, state: state};

    // Only the five named states ever appear
    state_legal_chk: assert property (
        @(posedge clk) disable iff (rst)
        state inside {dog_pkg::DOG_IDLE, dog_pkg::DOG_WALK, dog_pkg::DOG_SPOT,
                      dog_pkg::DOG_JUMP, dog_pkg::DOG_FALL}
    ) else $error("dog_ctl in illegal state %0d", state);

endmodule

//--- dog_draw.sv
// Dog overlay: paints a 32x32 box in the picture colour over the raster, one clock of latency
`timescale 1ns/10ps

module dog_draw (
    input  logic                 clk,
    input  logic                 rst,
    input  dog_pkg::vga_bus_t    vga_in,
    input  dog_pkg::dog_status_t dog,
    output dog_pkg::vga_bus_t    vga_out,
    output dog_pkg::dog_status_t dog_seen
);

    // ----------------------------------------
    // Box hit test
    // ----------------------------------------
    logic signed [12:0] dx, dy;    // Pixel offset inside the box
    logic               in_x, in_y;
    logic               active;    // Not in any blanking
    logic               hit;
    logic [3:0]         pal_idx;
    logic [11:0]        dog_rgb;
    dog_pkg::vga_bus_t  bus_nxt;

    // 13-bit signed so a box past x = 1023 still compares right
    assign dx = $signed({1'b0, vga_in.hcount}) - $signed({1'b0, dog.xpos});
    assign dy = $signed({1'b0, vga_in.vcount}) - $signed({1'b0, dog.ypos});

    assign in_x   = (dx >= 0) && (dx < dog_pkg::DOG_SIZE);
    assign in_y   = (dy >= 0) && (dy < dog_pkg::DOG_SIZE);
    assign active = !(vga_in.hblnk || vga_in.vblnk);
    assign hit    = active && in_x && in_y;

    // ----------------------------------------
    // Colour lookup
    // ----------------------------------------
    // Palette has nine entries, clamp anything above
    assign pal_idx = (dog.photo > 4'd8) ? 4'd8 : dog.photo;
    assign dog_rgb = dog_pkg::DOG_PALETTE[pal_idx];

    always_comb begin : pix_comb_blk
        bus_nxt = vga_in; // Timing passes straight on
        if (hit) begin
            bus_nxt.rgb = dog_rgb;
        end
    end

    // ----------------------------------------
    // Output register
    // ----------------------------------------
    always_ff @(posedge clk) begin : out_seq_blk
        if (rst) begin
            vga_out <= '0; // Syncs and blanks inactive
        end else begin
            vga_out <= bus_nxt;
        end
    end

    // Status follows the pixel it was drawn with
    always_ff @(posedge clk) begin : status_seq_blk
        dog_seen <= dog;
    end

endmodule

//--- dog_scene_top.sv
// Top of the dog layer: raster timing, dog controller and overlay; raster comes out one clock late
`timescale 1ns/10ps

module dog_scene_top #(
    parameter int H_ACTIVE = 1024,
    parameter int H_FRONT  = 24,
    parameter int H_SYNC   = 136,
    parameter int H_TOTAL  = 1344,
    parameter int V_ACTIVE = 768,
    parameter int V_FRONT  = 3,
    parameter int V_SYNC   = 6,
    parameter int V_TOTAL  = 806
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 game_enable,
    output dog_pkg::vga_bus_t    vga_out,
    output dog_pkg::dog_status_t dog_status
);

    // ----------------------------------------
    // Internal wiring
    // ----------------------------------------
    dog_pkg::vga_bus_t    timing_bus; // Background raster
    dog_pkg::dog_status_t ctl_status; // Live dog pose
    logic                 line_tick;  // Start of horizontal blank

    vga_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_TOTAL  (H_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_TOTAL  (V_TOTAL)
    ) u_vga_timing (
        .clk       (clk),
        .rst       (rst),
        .vga_out   (timing_bus),
        .line_tick (line_tick)
    );

    // Steps once per line, outside the visible area
    dog_ctl u_dog_ctl (
        .clk         (clk),
        .rst         (rst),
        .game_enable (game_enable),
        .line_tick   (line_tick),
        .dog         (ctl_status)
    );

    dog_draw u_dog_draw (
        .clk      (clk),
        .rst      (rst),
        .vga_in   (timing_bus),
        .dog      (ctl_status),
        .vga_out  (vga_out),
        .dog_seen (dog_status) // Status aligned with the drawn pixel
    );

endmodule

//--- dog_scene_tb.sv
// Self-checking testbench for the dog layer; simulate it as the top module with the src.f file list
`timescale 1ns/10ps

module dog_scene_tb;

    // ----------------------------------------
    // Raster geometry and run constants
    // ----------------------------------------
    localparam int     H_ACTIVE  = 1024;
    localparam int     H_FRONT   = 24;
    localparam int     H_SYNC    = 136;
    localparam int     H_TOTAL   = 1344;
    localparam int     V_ACTIVE  = 768;
    localparam int     V_FRONT   = 3;
    localparam int     V_SYNC    = 6;
    localparam int     V_TOTAL   = 806;
    localparam int     CLK_NS    = 20;
    localparam int     DRIVE_NS  = 2;          // Input skew after the rising edge
    localparam int     N_ROWS    = 4;
    localparam int     MAX_SHOWN = 40;         // Mismatch lines printed before going quiet
    localparam longint ONE       = 64'd1 << 24; // 1.0 in Q12.24

    // Stimulus table: name, enable level, line ticks to hold, states expected on the status
    // The last row runs past the frame end so vertical blank, sync and wrap are covered
    string      row_name  [N_ROWS] = '{"idle_hold", "walk_start", "full_path", "drop_mid_walk"};
    logic       row_en    [N_ROWS] = '{1'b0, 1'b1, 1'b1, 1'b0};
    int         row_ticks [N_ROWS] = '{200, 60, 200, 400};
    logic [4:0] row_mask  [N_ROWS] = '{5'b00001, 5'b00011, 5'b11111, 5'b11111}; // Bit n is state n

    logic                 clk;
    logic                 rst;
    logic                 game_enable;
    dog_pkg::vga_bus_t    vga_out;
    dog_pkg::dog_status_t dog_status;

    // Reference model of the path
    longint              m_x, m_y;   // Q12.24 position
    int                  m_photo;
    dog_pkg::dog_state_t m_state;
    int                  exp_hc, exp_vc; // Expected output counters
    logic                en_prev;        // Enable as the controller saw it

    // Bookkeeping
    logic [4:0] seen_mask;
    int         line_count;
    int         check_count;
    int         err_count;
    int         row_errs;
    string      cur_name;

    dog_scene_top uut (
        .clk         (clk),
        .rst         (rst),
        .game_enable (game_enable),
        .vga_out     (vga_out),
        .dog_status  (dog_status)
    );

    initial begin : clk_gen_blk
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic check(input string field, input logic [63:0] expv, input logic [63:0] actv);
        check_count++;
        if (expv !== actv) begin
            err_count++;
            row_errs++;
            if (err_count <= MAX_SHOWN) begin
                $display("[FAIL] %s %s: expected %0h, actual %0h at %0t ns",
                         cur_name, field, expv, actv, $time);
            end
        end
    endtask

    // One line-start step of the dog path
    task automatic step_model(input logic en);
        dog_pkg::dog_state_t nxt;
        longint              xi, yi;
        int                  phase;
        xi = m_x >>> 24; // Integer pixels
        yi = m_y >>> 24;
        case (m_state)
            dog_pkg::DOG_IDLE: nxt = en ? dog_pkg::DOG_WALK : dog_pkg::DOG_IDLE;
            dog_pkg::DOG_WALK: nxt = (xi >= 650) ? dog_pkg::DOG_WALK : dog_pkg::DOG_SPOT;
            dog_pkg::DOG_SPOT: nxt = (xi < 653) ? dog_pkg::DOG_SPOT : dog_pkg::DOG_JUMP;
            dog_pkg::DOG_JUMP: nxt = (yi > 450) ? dog_pkg::DOG_JUMP : dog_pkg::DOG_FALL;
            default:           nxt = (yi < 600) ? dog_pkg::DOG_FALL : dog_pkg::DOG_IDLE;
        endcase
        case (nxt)
            dog_pkg::DOG_IDLE: begin
                m_x     = 1024 * ONE; // Home pose
                m_y     = 595 * ONE;
                m_photo = 0;
            end
            dog_pkg::DOG_WALK: begin
                m_x     = m_x - 3 * ONE;
                phase   = int'(((m_x >>> 24) >> 3) % 8); // Integer x bits 5:3
                m_photo = (phase > 5) ? 0 : phase;
            end
            dog_pkg::DOG_SPOT: begin
                m_x     = m_x + ONE / 4;
                m_photo = 6;
            end
            dog_pkg::DOG_JUMP: begin
                m_x     = m_x - 2 * ONE;
                m_y     = m_y - 4 * ONE;
                m_photo = 7;
            end
            default: begin
                m_x     = m_x - 2 * ONE;
                m_y     = m_y + 3 * ONE;
                m_photo = 8;
            end
        endcase
        m_state = nxt;
    endtask

    // Bus expected at the current output pixel, box drawn from the model pose
    function automatic dog_pkg::vga_bus_t expected_bus();
        dog_pkg::vga_bus_t b;
        longint            dx, dy;
        b.hcount = 12'(exp_hc);
        b.vcount = 12'(exp_vc);
        b.hblnk  = (exp_hc >= H_ACTIVE);
        b.vblnk  = (exp_vc >= V_ACTIVE);
        b.hsync  = (exp_hc >= H_ACTIVE + H_FRONT) && (exp_hc < H_ACTIVE + H_FRONT + H_SYNC);
        b.vsync  = (exp_vc >= V_ACTIVE + V_FRONT) && (exp_vc < V_ACTIVE + V_FRONT + V_SYNC);
        dx       = exp_hc - (m_x >>> 24);
        dy       = exp_vc - (m_y >>> 24);
        b.rgb    = dog_pkg::BG_RGB;
        if (!b.hblnk && !b.vblnk && dx >= 0 && dx < 32 && dy >= 0 && dy < 32) begin
            b.rgb = dog_pkg::DOG_PALETTE[m_photo];
        end
        return b;
    endfunction

    function automatic dog_pkg::dog_status_t expected_status();
        dog_pkg::dog_status_t s;
        s.xpos  = 12'(m_x >>> 24);
        s.ypos  = 12'(m_y >>> 24);
        s.photo = 4'(m_photo);
        s.state = m_state;
        return s;
    endfunction

    // Returns just after a rising edge, plus the drive skew
    task automatic wait_lines(input int n);
        int target;
        target = line_count + n;
        while (line_count < target) begin
            @(posedge clk);
        end
        #(DRIVE_NS);
    endtask

    // ----------------------------------------
    // Output monitor, samples on the falling edge
    // ----------------------------------------
    initial begin : monitor_blk
        @(negedge rst);
        @(posedge clk); // First registered pixel after reset
        forever begin
            @(negedge clk);
            check("bus", expected_bus(), vga_out);
            check("status", expected_status(), dog_status);
            seen_mask[dog_status.state] = 1'b1;
            if (vga_out.hcount == 12'(H_ACTIVE)) begin
                step_model(en_prev); // New pose shows one clock later
                line_count++;
            end
            if (exp_hc == H_TOTAL - 1) begin
                exp_hc = 0;
                exp_vc = (exp_vc == V_TOTAL - 1) ? 0 : exp_vc + 1;
            end else begin
                exp_hc = exp_hc + 1;
            end
            en_prev = game_enable;
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin : stim_blk
        int i;
        rst         = 1'b1;
        game_enable = 1'b0;
        m_x         = 1024 * ONE;
        m_y         = 595 * ONE;
        m_photo     = 0;
        m_state     = dog_pkg::DOG_IDLE;
        exp_hc      = 0;
        exp_vc      = 0;
        en_prev     = 1'b0;
        seen_mask   = '0;
        line_count  = 0;
        check_count = 0;
        err_count   = 0;
        row_errs    = 0;
        cur_name    = "reset";
        repeat (10) @(posedge clk);
        #(DRIVE_NS);
        rst = 1'b0;
        for (i = 0; i < N_ROWS; i++) begin
            cur_name    = row_name[i];
            row_errs    = 0;
            seen_mask   = '0;
            game_enable = row_en[i];
            wait_lines(row_ticks[i]);
            check("state mask", row_mask[i], seen_mask); // Order itself checked per pixel
            $display("%s finished with %0d mismatches", cur_name, row_errs);
        end
        $display("Ran %0d tests, %0d checks, %0d mismatches", N_ROWS, check_count, err_count);
        if (err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Limit is every table line plus one spare frame
    initial begin : watchdog_blk
        longint limit_ns;
        int     i;
        limit_ns = longint'(H_TOTAL) * V_TOTAL * CLK_NS;
        for (i = 0; i < N_ROWS; i++) begin
            limit_ns = limit_ns + longint'(row_ticks[i]) * H_TOTAL * CLK_NS;
        end
        #(limit_ns);
        $display("Run timed out after %0d ns before the stimulus table finished", limit_ns);
        $display("Test FAILED");
        $finish;
    end

endmodule

//--- src.f
dog_pkg.sv
vga_timing.sv
dog_ctl.sv
dog_draw.sv
dog_scene_top.sv
dog_scene_tb.sv
